/* hdl/icache_pkg.sv */
package icache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Byte address of the instruction to fetch
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] instr;
    } fetch_rsp_t;

    // Word-aligned address of the critical word of a burst
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } mem_beat_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_load_t;

    typedef enum logic [1:0] {
        ic_idle,
        ic_refill,
        ic_install
    } icache_state_e;

    typedef enum logic [1:0] {
        pf_empty,
        pf_requesting,
        pf_filling,
        pf_full
    } prefetch_state_e;

endpackage

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                Clk,
    input  logic                                reset,
    input  logic                                fetch_valid,
    input  fetch_req_t                          fetch_req,
    output logic                                fetch_ready,
    input  logic                                flush,
    output logic                                rsp_valid,
    output fetch_rsp_t                          rsp,
    output logic                                dmd_valid,
    output mem_req_t                            dmd_req,
    input  logic                                dmd_ready,
    input  logic                                dmd_beat_valid,
    input  mem_beat_t                           dmd_beat,
    output logic [ADDR_W-1:0]                   lk_addr,
    input  logic                                lk_hit,
    input  logic [BLOCK_WORDS-1:0][DATA_W-1:0]  lk_block,
    output logic                                lk_take,
    output logic                                pf_start,
    output logic [ADDR_W-1:0]                   pf_addr
);

    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int BLK_LSB = OFF_W + 2;
    localparam int TAG_W = ADDR_W - IDX_W - BLK_LSB;

    typedef logic [BLOCK_WORDS-1:0][DATA_W-1:0] block_t;

    // Cache arrays
    logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    block_t              data_q  [NUM_SETS][NUM_WAYS];
    logic [WAY_W-1:0]    rr_q    [NUM_SETS];

    icache_state_e     state_q;
    logic [ADDR_W-1:0] req_addr_q;
    logic [OFF_W-1:0]  beat_off_q;
    logic              first_q;
    logic              flushed_q;
    block_t            fill_q;
    block_t            fill_next;

    logic [IDX_W-1:0]  req_idx;
    logic [TAG_W-1:0]  req_tag;
    logic [OFF_W-1:0]  req_off;
    logic [IDX_W-1:0]  wr_idx;
    logic [TAG_W-1:0]  wr_tag;
    logic              accept;
    logic              hit;
    logic [WAY_W-1:0]  hit_way;
    logic              last_beat;
    logic              wr_en;
    block_t            wr_block;

    assign req_idx = fetch_req.addr[BLK_LSB +: IDX_W];
    assign req_tag = fetch_req.addr[ADDR_W-1 -: TAG_W];
    assign req_off = fetch_req.addr[2 +: OFF_W];
    assign wr_idx  = req_addr_q[BLK_LSB +: IDX_W];
    assign wr_tag  = req_addr_q[ADDR_W-1 -: TAG_W];

    assign accept = fetch_valid && fetch_ready;

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[req_idx][w] && tag_q[req_idx][w] == req_tag) begin
                hit = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    // Prefetch buffer is only consulted when the cache misses
    assign lk_addr = fetch_req.addr;
    assign lk_take = accept && !hit && lk_hit;

    // Beats arrive critical word first and wrap inside the block
    always_comb begin
        fill_next = fill_q;
        fill_next[beat_off_q] = dmd_beat.data;
    end

    assign last_beat = (state_q == ic_refill) && dmd_beat_valid && dmd_beat.last;
    assign wr_en     = last_beat || (state_q == ic_install);
    assign wr_block  = (state_q == ic_install) ? fill_q : fill_next;

    // Next sequential block goes to the prefetcher
    assign pf_start = last_beat;
    assign pf_addr  = {req_addr_q[ADDR_W-1:BLK_LSB] + 1'b1, {BLK_LSB{1'b0}}};

    always_ff @(posedge Clk) begin
        if (reset) begin
            state_q     <= ic_idle;
            fetch_ready <= 1'b0;
            rsp_valid   <= 1'b0;
            dmd_valid   <= 1'b0;
            first_q     <= 1'b0;
            flushed_q   <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else begin
            rsp_valid <= 1'b0;
            if (dmd_valid && dmd_ready) begin
                dmd_valid <= 1'b0;
            end
            case (state_q)
                ic_idle: begin
                    fetch_ready <= 1'b1;
                    if (accept) begin
                        if (hit) begin
                            rsp_valid <= 1'b1;
                        end else if (lk_hit) begin
                            rsp_valid   <= 1'b1;
                            fetch_ready <= 1'b0;
                            state_q     <= ic_install;
                        end else begin
                            dmd_valid   <= 1'b1;
                            first_q     <= 1'b1;
                            flushed_q   <= 1'b0;
                            fetch_ready <= 1'b0;
                            state_q     <= ic_refill;
                        end
                    end
                end
                ic_refill: begin
                    if (flush) begin
                        flushed_q <= 1'b1;
                    end
                    if (dmd_beat_valid) begin
                        first_q <= 1'b0;
                        // A flush on the first beat also drops the answer
                        if (first_q && !flushed_q && !flush) begin
                            rsp_valid <= 1'b1;
                        end
                        if (dmd_beat.last) begin
                            fetch_ready <= 1'b1;
                            state_q     <= ic_idle;
                        end
                    end
                end
                ic_install: begin
                    fetch_ready <= 1'b1;
                    state_q     <= ic_idle;
                end
                default: begin
                    state_q <= ic_idle;
                end
            endcase
            if (wr_en) begin
                valid_q[wr_idx][rr_q[wr_idx]] <= 1'b1;
                rr_q[wr_idx] <= rr_q[wr_idx] + 1'b1;
            end
        end
    end

    // Payload and arrays
    always_ff @(posedge Clk) begin
        if (accept) begin
            req_addr_q   <= fetch_req.addr;
            beat_off_q   <= req_off;
            dmd_req.addr <= {fetch_req.addr[ADDR_W-1:2], 2'b00};
            if (hit) begin
                rsp <= '{addr: fetch_req.addr, instr: data_q[req_idx][hit_way][req_off]};
            end else if (lk_hit) begin
                rsp    <= '{addr: fetch_req.addr, instr: lk_block[req_off]};
                fill_q <= lk_block;
            end
        end
        if (state_q == ic_refill && dmd_beat_valid) begin
            fill_q     <= fill_next;
            beat_off_q <= beat_off_q + 1'b1;
            if (first_q) begin
                rsp <= '{addr: req_addr_q, instr: dmd_beat.data};
            end
        end
        if (wr_en) begin
            data_q[wr_idx][rr_q[wr_idx]] <= wr_block;
            tag_q[wr_idx][rr_q[wr_idx]]  <= wr_tag;
        end
    end

    // A flushed miss still refills but never answers
    assert property (@(posedge Clk) disable iff (reset)
        (state_q == ic_refill && flushed_q) |=> !rsp_valid);

    assert property (@(posedge Clk) disable iff (reset)
        (dmd_valid && !dmd_ready) |=> dmd_valid);

endmodule

/* hdl/icache_prefetch.sv */
`timescale 1ns/1ps

module icache_prefetch
    import icache_pkg::*;
#(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                                Clk,
    input  logic                                reset,
    input  logic                                pf_start,
    input  logic [ADDR_W-1:0]                   pf_addr,
    input  logic [ADDR_W-1:0]                   lk_addr,
    output logic                                lk_hit,
    output logic [BLOCK_WORDS-1:0][DATA_W-1:0]  lk_block,
    input  logic                                lk_take,
    input  logic                                dmd_valid,
    input  mem_req_t                            dmd_req,
    output logic                                dmd_ready,
    output logic                                dmd_beat_valid,
    output mem_beat_t                           dmd_beat,
    output logic                                mem_valid,
    output mem_req_t                            mem_req,
    input  logic                                mem_ready,
    input  logic                                mem_beat_valid,
    input  mem_beat_t                           mem_beat
);

    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int BLK_LSB = OFF_W + 2;

    prefetch_state_e   pf_state_q;
    logic [ADDR_W-1:0] pf_addr_q;
    logic [OFF_W-1:0]  pf_off_q;
    logic              busy_q;
    logic              owner_dmd_q;
    logic              accept;
    logic              pf_beat;

    assign lk_hit = (pf_state_q == pf_full) &&
                    (lk_addr[ADDR_W-1:BLK_LSB] == pf_addr_q[ADDR_W-1:BLK_LSB]);

    // Demand always wins the port, a waiting prefetch is simply not presented
    assign mem_valid = dmd_valid || (pf_state_q == pf_requesting);
    assign mem_req   = dmd_valid ? dmd_req : '{addr: pf_addr_q};
    assign dmd_ready = mem_ready;
    assign accept    = mem_valid && mem_ready;

    // Route beats to whoever owns the burst
    assign dmd_beat_valid = mem_beat_valid && owner_dmd_q;
    assign dmd_beat       = mem_beat;
    assign pf_beat        = mem_beat_valid && !owner_dmd_q;

    always_ff @(posedge Clk) begin
        if (reset) begin
            pf_state_q  <= pf_empty;
            busy_q      <= 1'b0;
            owner_dmd_q <= 1'b0;
        end else begin
            if (accept) begin
                busy_q      <= 1'b1;
                owner_dmd_q <= dmd_valid;
            end else if (mem_beat_valid && mem_beat.last) begin
                busy_q <= 1'b0;
            end
            case (pf_state_q)
                pf_empty: begin
                    if (pf_start) begin
                        pf_state_q <= pf_requesting;
                    end
                end
                pf_requesting: begin
                    // Cancelled if a demand miss takes the port first
                    if (dmd_valid) begin
                        pf_state_q <= pf_empty;
                    end else if (mem_ready) begin
                        pf_state_q <= pf_filling;
                    end
                end
                pf_filling: begin
                    if (pf_beat && mem_beat.last) begin
                        pf_state_q <= pf_full;
                    end
                end
                default: begin
                    if (pf_start) begin
                        pf_state_q <= pf_requesting;
                    end else if (lk_take) begin
                        pf_state_q <= pf_empty;
                    end
                end
            endcase
        end
    end

    // Prefetch asks for word 0, so beats land in order
    always_ff @(posedge Clk) begin
        if (pf_start) begin
            pf_addr_q <= pf_addr;
            pf_off_q  <= '0;
        end else if (pf_beat) begin
            lk_block[pf_off_q] <= mem_beat.data;
            pf_off_q           <= pf_off_q + 1'b1;
        end
    end

    assert property (@(posedge Clk) disable iff (reset) mem_beat_valid |-> busy_q);

endmodule

/* hdl/sdram_ctrl.sv */
`timescale 1ns/1ps

module sdram_ctrl
    import icache_pkg::*;
#(
    parameter int BLOCK_WORDS = 4,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3
) (
    input  logic      Clk,
    input  logic      reset,
    input  logic      mem_valid,
    input  mem_req_t  mem_req,
    output logic      mem_ready,
    output logic      mem_beat_valid,
    output mem_beat_t mem_beat,
    input  logic      load_valid,
    input  mem_load_t load
);

    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int LAT_W = $clog2(MEM_LATENCY + 1);

    logic [DATA_W-1:0] mem_q [MEM_WORDS];

    logic                    wait_q;
    logic                    burst_q;
    logic [LAT_W-1:0]        lat_q;
    logic [OFF_W-1:0]        beat_q;
    logic [MEM_AW-OFF_W-1:0] blk_q;
    logic [OFF_W-1:0]        off_q;

    // Word offset wraps inside the block
    assign mem_beat_valid = burst_q;
    assign mem_beat.data  = mem_q[{blk_q, off_q}];
    assign mem_beat.last  = burst_q && (beat_q == OFF_W'(BLOCK_WORDS - 1));

    always_ff @(posedge Clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
            wait_q    <= 1'b0;
            burst_q   <= 1'b0;
            lat_q     <= '0;
            beat_q    <= '0;
        end else begin
            if (mem_valid && mem_ready) begin
                // First beat shows up MEM_LATENCY cycles after acceptance
                mem_ready <= 1'b0;
                wait_q    <= 1'b1;
                lat_q     <= LAT_W'(MEM_LATENCY - 2);
                beat_q    <= '0;
            end else if (wait_q) begin
                if (lat_q == '0) begin
                    wait_q  <= 1'b0;
                    burst_q <= 1'b1;
                end else begin
                    lat_q <= lat_q - 1'b1;
                end
            end else if (burst_q) begin
                beat_q <= beat_q + 1'b1;
                if (mem_beat.last) begin
                    burst_q   <= 1'b0;
                    mem_ready <= 1'b1;
                end
            end else begin
                mem_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (mem_valid && mem_ready) begin
            blk_q <= mem_req.addr[2+OFF_W +: MEM_AW-OFF_W];
            off_q <= mem_req.addr[2 +: OFF_W];
        end else if (burst_q) begin
            off_q <= off_q + 1'b1;
        end
        if (load_valid) begin
            mem_q[load.addr[2 +: MEM_AW]] <= load.data;
        end
    end

    // Preload only happens while the memory is quiet
    assert property (@(posedge Clk) disable iff (reset) load_valid |-> !(wait_q || burst_q));

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3
) (
    input  logic       Clk,
    input  logic       reset,
    input  logic       fetch_valid,
    input  fetch_req_t fetch_req,
    output logic       fetch_ready,
    input  logic       flush,
    output logic       rsp_valid,
    output fetch_rsp_t rsp,
    input  logic       load_valid,
    input  mem_load_t  load
);

    logic                               dmd_valid;
    mem_req_t                           dmd_req;
    logic                               dmd_ready;
    logic                               dmd_beat_valid;
    mem_beat_t                          dmd_beat;
    logic [ADDR_W-1:0]                  lk_addr;
    logic                               lk_hit;
    logic [BLOCK_WORDS-1:0][DATA_W-1:0] lk_block;
    logic                               lk_take;
    logic                               pf_start;
    logic [ADDR_W-1:0]                  pf_addr;
    logic                               mem_valid;
    mem_req_t                           mem_req;
    logic                               mem_ready;
    logic                               mem_beat_valid;
    mem_beat_t                          mem_beat;

    icache_ctrl #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_ctrl (
        .Clk            (Clk),
        .reset          (reset),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .fetch_ready    (fetch_ready),
        .flush          (flush),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .dmd_valid      (dmd_valid),
        .dmd_req        (dmd_req),
        .dmd_ready      (dmd_ready),
        .dmd_beat_valid (dmd_beat_valid),
        .dmd_beat       (dmd_beat),
        .lk_addr        (lk_addr),
        .lk_hit         (lk_hit),
        .lk_block       (lk_block),
        .lk_take        (lk_take),
        .pf_start       (pf_start),
        .pf_addr        (pf_addr)
    );

    icache_prefetch #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_prefetch (
        .Clk            (Clk),
        .reset          (reset),
        .pf_start       (pf_start),
        .pf_addr        (pf_addr),
        .lk_addr        (lk_addr),
        .lk_hit         (lk_hit),
        .lk_block       (lk_block),
        .lk_take        (lk_take),
        .dmd_valid      (dmd_valid),
        .dmd_req        (dmd_req),
        .dmd_ready      (dmd_ready),
        .dmd_beat_valid (dmd_beat_valid),
        .dmd_beat       (dmd_beat),
        .mem_valid      (mem_valid),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat)
    );

    sdram_ctrl #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_sdram (
        .Clk            (Clk),
        .reset          (reset),
        .mem_valid      (mem_valid),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat),
        .load_valid     (load_valid),
        .load           (load)
    );

endmodule

/* test/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top
    import icache_pkg::*;
();

    logic       Clk;
    logic       reset;
    logic       fetch_valid;
    fetch_req_t fetch_req;
    logic       fetch_ready;
    logic       flush;
    logic       rsp_valid;
    fetch_rsp_t rsp;
    logic       load_valid;
    mem_load_t  load;

    // Contents of the data file
    logic [ADDR_W-1:0] pre_addr [$];
    logic [DATA_W-1:0] pre_data [$];
    string             f_name   [$];
    logic [ADDR_W-1:0] f_addr   [$];
    int                f_flush  [$];
    int                f_fast   [$];
    int                f_idle   [$];
    logic [DATA_W-1:0] f_instr  [$];

    // Fetches still owed a response, oldest first
    string             out_name  [$];
    logic [ADDR_W-1:0] out_addr  [$];
    logic [DATA_W-1:0] out_instr [$];
    int                out_fast  [$];
    int                out_cycle [$];

    int cycle = 0;
    int limit_cycles = 0;
    int errors = 0;
    int passed = 0;
    int failed = 0;

    fetch_top u_dut (
        .Clk         (Clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .fetch_ready (fetch_ready),
        .flush       (flush),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .load_valid  (load_valid),
        .load        (load)
    );

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycle <= cycle + 1;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("PASS %s", name);
        end else begin
            failed++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic read_testdata();
        int          fd;
        int          n;
        int          fl;
        int          fast;
        int          idle;
        string       line;
        string       name;
        logic [31:0] addr;
        logic [31:0] word;
        fd = $fopen("test/fetch_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open test/fetch_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                if (line[0] == "L" && $sscanf(line, "L %h %h", addr, word) == 2) begin
                    pre_addr.push_back(addr);
                    pre_data.push_back(word);
                end else if (line[0] == "F" &&
                             $sscanf(line, "F %s %h %d %d %d %h",
                                     name, addr, fl, fast, idle, word) == 6) begin
                    f_name.push_back(name);
                    f_addr.push_back(addr);
                    f_flush.push_back(fl);
                    f_fast.push_back(fast);
                    f_idle.push_back(idle);
                    f_instr.push_back(word);
                end else begin
                    errors++;
                    $display("Could not parse data file line %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // Holds the request until accepted, then owes a response or flushes it
    task automatic issue_fetch(input int i);
        int acc_cycle;
        int errors_before;
        fetch_valid = 1'b1;
        fetch_req   = '{addr: f_addr[i]};
        @(negedge Clk);
        while (!fetch_ready) @(negedge Clk);
        // Cycle in which valid and ready are both high
        acc_cycle = cycle;
        @(posedge Clk);
        #2;
        fetch_valid = 1'b0;
        if (f_flush[i] == 0) begin
            out_name.push_back(f_name[i]);
            out_addr.push_back(f_addr[i]);
            out_instr.push_back(f_instr[i]);
            out_fast.push_back(f_fast[i]);
            out_cycle.push_back(acc_cycle);
        end else begin
            errors_before = errors;
            // Lands while the miss is still waiting for its first beat
            flush = 1'b1;
            @(posedge Clk);
            #2;
            flush = 1'b0;
            @(negedge Clk);
            while (!fetch_ready) @(negedge Clk);
            @(posedge Clk);
            #2;
            report_test(f_name[i], errors_before);
        end
    endtask

    initial begin : response_monitor
        int    errors_before;
        int    acc;
        int    fast;
        string name;
        forever begin
            @(negedge Clk);
            if (rsp_valid === 1'b1) begin
                if (out_addr.size() == 0) begin
                    errors++;
                    $display("Unexpected response for address %h with no fetch outstanding",
                             rsp.addr);
                end else begin
                    errors_before = errors;
                    name = out_name.pop_front();
                    acc  = out_cycle.pop_front();
                    fast = out_fast.pop_front();
                    compare_value({name, " address"}, out_addr.pop_front(), rsp.addr);
                    compare_value(name, out_instr.pop_front(), rsp.instr);
                    if (fast != 0) begin
                        compare_value({name, " latency"}, 32'd1, 32'(cycle - acc));
                    end
                    report_test(name, errors_before);
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        while (cycle < limit_cycles) @(negedge Clk);
        $display("Timeout after %0d cycles with %0d fetches still waiting for a response",
                 cycle, out_addr.size());
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        int gap;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        flush       = 1'b0;
        load_valid  = 1'b0;
        load        = '0;
        void'($urandom(42));
        read_testdata();
        limit_cycles = 40 * f_name.size() + 8 + pre_addr.size() + 2;
        repeat (8) @(posedge Clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < pre_addr.size(); i++) begin
            load_valid = 1'b1;
            load       = '{addr: pre_addr[i], data: pre_data[i]};
            @(posedge Clk);
            #2;
        end
        load_valid = 1'b0;
        if (f_name.size() == 0) begin
            errors++;
            $display("No fetch lines found in the data file");
        end
        for (int i = 0; i < f_name.size(); i++) begin
            gap = $urandom_range(3, 0) + f_idle[i];
            repeat (gap) begin
                @(posedge Clk);
                #2;
            end
            issue_fetch(i);
        end
        while (out_addr.size() != 0) @(negedge Clk);
        repeat (4) @(posedge Clk);
        $display("Tests %0d, passed %0d, failed %0d, mismatches %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && failed == 0 && passed == f_name.size()) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* test/fetch_testdata.txt */
# L lines preload memory with columns byte address and word
# F lines fetch with columns name, byte address, flush, one-cycle answer, idle cycles, word
L 00000040 1a2b0040
L 00000048 1a2b0048
L 0000004c 1a2b004c
L 00000054 2c3d0054
L 00000058 2c3d0058
L 000000a4 3e4f00a4
L 000000e8 4051a0e8
L 00000004 5f6e0004
L 00000080 6d7c0080
L 00000108 7b8a0108
L 0000018c 8998018c
L 00000200 97a60200
L 000003c8 a5b403c8
F cold_off2 00000048 0 0 0 1a2b0048
F asm_off0 00000040 0 1 0 1a2b0040
F asm_off3 0000004c 0 1 0 1a2b004c
F pf_hit 00000054 0 1 12 2c3d0054
F pf_installed 00000058 0 1 0 2c3d0058
F miss_first 000000a4 0 0 0 3e4f00a4
F miss_second 000000e8 0 0 0 4051a0e8
F set0_blk0 00000004 0 0 0 5f6e0004
F set0_blk1 00000080 0 0 0 6d7c0080
F set0_blk2 00000108 0 0 0 7b8a0108
F set0_blk3 0000018c 0 0 0 8998018c
F set0_blk4 00000200 0 0 0 97a60200
F evict_refetch 00000004 0 0 0 5f6e0004
F flushed_miss 000003c8 1 0 0 a5b403c8
F flush_filled 000003c8 0 1 0 a5b403c8

/* project.f */
hdl/icache_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_prefetch.sv
hdl/sdram_ctrl.sv
hdl/fetch_top.sv
test/tb_fetch_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_fetch_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not report a pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
